// File: Makefile
TOP = tb_ifmap_stage

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: cnn_cfg_pkg.sv
package cnn_cfg_pkg;

    // array geometry
    localparam int COL_NUM    = 32;  // PE columns
    localparam int FIFO_DEPTH = 4;   // bytes per column store, one beat

    typedef logic [$clog2(COL_NUM)-1:0] col_idx_t;

    typedef enum logic {
        MODE_PW = 1'b0,  // pointwise
        MODE_DW = 1'b1   // depthwise
    } layer_mode_e;

    // layer configuration, 12 bits
    typedef struct packed {
        layer_mode_e mode;
        logic        stride2;   // column counter steps by two
        col_idx_t    last_col;  // counter wraps once it reaches this column
        col_idx_t    dw_start;  // depthwise start column, counter begins 3 below
    } layer_cfg_t;

endpackage

// File: cnn_data_pkg.sv
package cnn_data_pkg;

    // one ifmap beat from the global buffer, b0 leaves its column first
    typedef struct packed {
        logic [7:0] b3;
        logic [7:0] b2;
        logic [7:0] b1;
        logic [7:0] b0;
    } ifmap_beat_t;

    // one shifted byte per column
    typedef logic [cnn_cfg_pkg::COL_NUM-1:0][7:0] col_bytes_t;

    // weight k of a column multiplies the k-th byte out of that column
    typedef logic [cnn_cfg_pkg::COL_NUM-1:0][cnn_cfg_pkg::FIFO_DEPTH-1:0][7:0] weight_set_t;

    // 4 x 255 x 255 fits in 18 bits
    typedef logic [17:0] psum_t;

    typedef psum_t [cnn_cfg_pkg::COL_NUM-1:0] psum_row_t;

endpackage

// File: ifmap_credit_rx.sv
`timescale 1ns/100ps

module ifmap_credit_rx #(
    parameter int CREDITS = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      beat_valid,
    input  cnn_data_pkg::ifmap_beat_t beat,
    output logic                      wr_valid,
    output cnn_data_pkg::ifmap_beat_t wr_beat,
    input  logic                      wr_ready,
    output logic                      credit_return
);
    import cnn_data_pkg::*;

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    ifmap_beat_t      mem [CREDITS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push     = beat_valid;            // never refused, credits bound the queue
    assign wr_valid = (count != '0);
    assign wr_beat  = mem[rd_ptr];
    assign pop      = wr_valid && wr_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= beat;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count         <= count + CNT_W'(push) - CNT_W'(pop);
            credit_return <= pop;  // one credit back per popped beat
        end
    end

    // a beat into a full queue means the sender spent a credit it did not hold
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        beat_valid |-> (count != CNT_W'(CREDITS)));

endmodule

// File: ifmap_stage_top.sv
`timescale 1ns/100ps

module ifmap_stage_top #(
    parameter int CREDITS = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      beat_valid,
    input  cnn_data_pkg::ifmap_beat_t beat,
    output logic                      credit_return,
    input  logic                      cfg_load,
    input  cnn_cfg_pkg::layer_cfg_t   cfg,
    input  logic                      start,
    input  cnn_data_pkg::weight_set_t weights,
    output logic                      busy,
    output logic                      psum_valid,
    output cnn_data_pkg::psum_row_t   psum
);
    import cnn_data_pkg::*;

    logic        wr_valid;
    logic        wr_ready;
    ifmap_beat_t wr_beat;
    col_bytes_t  col_bytes;  // one byte per column during the shift window

    ifmap_credit_rx #(
        .CREDITS (CREDITS)
    ) ifmap_credit_rx_inst (
        .clk           (clk),
        .reset         (reset),
        .beat_valid    (beat_valid),
        .beat          (beat),
        .wr_valid      (wr_valid),
        .wr_beat       (wr_beat),
        .wr_ready      (wr_ready),
        .credit_return (credit_return)
    );

    vertical_buffer vertical_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .cfg_load  (cfg_load),
        .cfg       (cfg),
        .wr_valid  (wr_valid),
        .wr_beat   (wr_beat),
        .wr_ready  (wr_ready),
        .start     (start),
        .busy      (busy),
        .col_bytes (col_bytes)
    );

    pe_column_array pe_column_array_inst (
        .clk        (clk),
        .reset      (reset),
        .busy       (busy),
        .col_bytes  (col_bytes),
        .weights    (weights),
        .psum_valid (psum_valid),
        .psum       (psum)
    );

endmodule

// File: pe_column_array.sv
`timescale 1ns/100ps

module pe_column_array (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      busy,
    input  cnn_data_pkg::col_bytes_t  col_bytes,
    input  cnn_data_pkg::weight_set_t weights,
    output logic                      psum_valid,
    output cnn_data_pkg::psum_row_t   psum
);
    import cnn_cfg_pkg::*;
    import cnn_data_pkg::*;

    logic [1:0] step;    // which byte of the shift-out is on col_bytes
    psum_t      acc [COL_NUM];
    psum_t      prod [COL_NUM];

    always_ff @(posedge clk) begin
        if (reset) begin
            step       <= '0;
            psum_valid <= 1'b0;
        end else begin
            if (busy) begin
                step <= step + 1'b1;  // wraps back to 0 after the fourth byte
            end
            // last busy cycle, busy falls on the next one
            psum_valid <= busy && (step == 2'd3);
        end
    end

    always_comb begin
        for (int c = 0; c < COL_NUM; c++) begin
            prod[c] = psum_t'(col_bytes[c]) * psum_t'(weights[c][step]);  // 8x8 unsigned
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < COL_NUM; c++) begin
            if (busy) begin
                if (step == 2'd0) begin
                    acc[c] <= prod[c];  // first byte starts a fresh sum
                end else begin
                    acc[c] <= acc[c] + prod[c];
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < COL_NUM; c++) begin
            psum[c] = acc[c];
        end
    end

    // every shift window ends in one psum_valid pulse right behind it
    a_psum_after_window: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> psum_valid);

endmodule

// File: sim.f
+incdir+.
cnn_cfg_pkg.sv
cnn_data_pkg.sv
ifmap_credit_rx.sv
vertical_buffer.sv
pe_column_array.sv
ifmap_stage_top.sv
tb_ifmap_stage.sv

// File: tb_ifmap_tasks.svh
task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("mismatch %s: got %h, expected %h", name, actual, expected);
    end
endtask

task automatic new_weights();
    for (int c = 0; c < COL_NUM; c++) begin
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            weights[c][k] = 8'($random(seed));
        end
    end
endtask

task automatic load_config(input layer_mode_e mode, input logic stride2,
                           input int last_col, input int dw_start);
    layer_cfg_t lc;
    lc.mode     = mode;
    lc.stride2  = stride2;
    lc.last_col = col_idx_t'(last_col);
    lc.dw_start = col_idx_t'(dw_start);
    cfg      = lc;
    cfg_load = 1'b1;
    model_config(lc);
    @(negedge clk);
    cfg_load = 1'b0;
endtask

// drives one beat for the coming edge, the caller lowers beat_valid
task automatic put_beat();
    ifmap_beat_t b;
    b          = ifmap_beat_t'($random(seed));
    beat       = b;
    beat_valid = 1'b1;
    model_write(b);
    sent++;
endtask

task automatic send_beats(input int n);
    int waited;
    for (int i = 0; i < n; i++) begin
        waited = 0;
        while (sent - returned >= CREDITS && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (sent - returned >= CREDITS) begin
            $display("timeout waiting for a credit before beat %0d", i);
            errors++;
            return;
        end
        put_beat();
        @(negedge clk);
        beat_valid = 1'b0;
    end
endtask

task automatic wait_credits_back();
    int waited;
    waited = 0;
    while (returned != sent && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    if (returned != sent) begin
        $display("timeout, %0d credits never came back", sent - returned);
        errors++;
    end
endtask

// start a shift-out, optionally pushing beats into the busy window
task automatic run_start(input int beats_during);
    int exp_psum [COL_NUM];
    int cycles;
    int left;
    bit done;
    for (int c = 0; c < COL_NUM; c++) begin
        exp_psum[c] = model_psum(c);
    end
    model_clear();
    start  = 1'b1;
    cycles = 0;
    left   = beats_during;
    done   = 1'b0;
    while (!done && cycles < TIMEOUT) begin
        @(negedge clk);
        cycles++;
        start      = 1'b0;
        beat_valid = 1'b0;
        if (cycles <= FIFO_DEPTH + 1) begin
            // high for the four cycles after start, low on the fifth
            check_value("busy", 32'(busy), 32'(cycles <= FIFO_DEPTH));
        end
        if (cycles <= FIFO_DEPTH) begin
            check_value("credit_return", 32'(credit_return), 32'(0));  // queue is held
        end
        if (psum_valid) begin
            done = 1'b1;
        end else if (left > 0 && sent - returned < CREDITS) begin
            put_beat();
            left--;
        end
    end
    if (!done) begin
        $display("timeout waiting for psum_valid after start");
        errors++;
        return;
    end
    check_value("start to psum_valid cycles", 32'(cycles), 32'(5));
    for (int c = 0; c < COL_NUM; c++) begin
        check_value($sformatf("psum[%0d]", c), 32'(psum[c]), 32'(exp_psum[c]));
    end
endtask

task automatic test_reset_state();
    check_value("credit_return", 32'(credit_return), 32'(0));
    check_value("busy", 32'(busy), 32'(0));
    check_value("psum_valid", 32'(psum_valid), 32'(0));
    new_weights();
    run_start(0);  // empty stores give zero sums
endtask

task automatic test_pointwise();
    load_config(MODE_PW, 1'b0, 31, 0);
    send_beats(32);
    wait_credits_back();
    new_weights();
    run_start(0);
endtask

task automatic test_depthwise();
    load_config(MODE_DW, 1'b0, 9, 5);  // columns 2 to 9, then back to 2
    send_beats(12);
    wait_credits_back();
    new_weights();
    run_start(0);
endtask

task automatic test_stride2();
    load_config(MODE_PW, 1'b1, 30, 0);
    send_beats(16);
    wait_credits_back();
    new_weights();
    run_start(0);
endtask

task automatic test_backpressure();
    load_config(MODE_PW, 1'b0, 31, 0);
    send_beats(3);
    wait_credits_back();
    new_weights();
    run_start(CREDITS);  // these beats sit queued until busy falls
    wait_credits_back();
    send_beats(4);
    wait_credits_back();
    new_weights();
    run_start(0);
endtask

// File: tb_ifmap_stage.sv
`timescale 1ns/100ps

module tb_ifmap_stage;
    import cnn_cfg_pkg::*;
    import cnn_data_pkg::*;

    localparam int CREDITS = 2;
    localparam int TIMEOUT = 100;  // cycles any single wait may take

    logic        clk;
    logic        reset;
    logic        beat_valid;
    ifmap_beat_t beat;
    logic        credit_return;
    logic        cfg_load;
    layer_cfg_t  cfg;
    logic        start;
    weight_set_t weights;
    logic        busy;
    logic        psum_valid;
    psum_row_t   psum;

    integer seed = 32'h8804;
    int     errors = 0;
    int     checks = 0;
    int     sent = 0;      // beats handed to the DUT
    int     returned = 0;  // credit_return pulses seen

    // reference model of the column stores and the column counter
    logic [7:0] model_store [COL_NUM][FIFO_DEPTH];
    int         model_col;
    int         model_restart;
    int         model_last;
    int         model_step;

    ifmap_stage_top #(
        .CREDITS (CREDITS)
    ) ifmap_stage_top_inst (
        .clk           (clk),
        .reset         (reset),
        .beat_valid    (beat_valid),
        .beat          (beat),
        .credit_return (credit_return),
        .cfg_load      (cfg_load),
        .cfg           (cfg),
        .start         (start),
        .weights       (weights),
        .busy          (busy),
        .psum_valid    (psum_valid),
        .psum          (psum)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // one credit per pulse, counted at the edge that ends the pulse
    always @(posedge clk) begin
        if (!reset && credit_return) begin
            if (returned >= sent) begin
                $display("credit returned while no beat was outstanding");
                errors++;
            end else begin
                returned++;
            end
        end
    end

    // shift-out leaves every store zero filled
    function automatic void model_clear();
        for (int c = 0; c < COL_NUM; c++) begin
            for (int k = 0; k < FIFO_DEPTH; k++) begin
                model_store[c][k] = 8'h00;
            end
        end
    endfunction

    function automatic void model_config(input layer_cfg_t lc);
        // depthwise starts three columns before dw_start, wrapping
        model_col     = (lc.mode == MODE_DW) ? ((int'(lc.dw_start) - 3 + COL_NUM) % COL_NUM) : 0;
        model_restart = model_col;
        model_last    = int'(lc.last_col);
        model_step    = lc.stride2 ? 2 : 1;
    endfunction

    function automatic void model_write(input ifmap_beat_t b);
        model_store[model_col][0] = b.b0;  // first byte out
        model_store[model_col][1] = b.b1;
        model_store[model_col][2] = b.b2;
        model_store[model_col][3] = b.b3;
        if (model_col >= model_last) begin
            model_col = model_restart;
        end else begin
            model_col = (model_col + model_step) % COL_NUM;
        end
    endfunction

    function automatic int model_psum(input int c);
        int sum;
        sum = 0;
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            sum += int'(model_store[c][k]) * int'(weights[c][k]);
        end
        return sum;
    endfunction

    `include "tb_ifmap_tasks.svh"

    initial begin
        reset      = 1'b1;
        beat_valid = 1'b0;
        beat       = '0;
        cfg_load   = 1'b0;
        cfg        = '0;
        start      = 1'b0;
        weights    = '0;
        model_clear();
        model_config('0);  // reset state is pointwise, last_col 0
        repeat (3) @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_pointwise();
        test_depthwise();
        test_stride2();
        test_backpressure();

        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: vertical_buffer.sv
`timescale 1ns/100ps

module vertical_buffer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cfg_load,
    input  cnn_cfg_pkg::layer_cfg_t   cfg,
    input  logic                      wr_valid,
    input  cnn_data_pkg::ifmap_beat_t wr_beat,
    output logic                      wr_ready,
    input  logic                      start,
    output logic                      busy,
    output cnn_data_pkg::col_bytes_t  col_bytes
);
    import cnn_cfg_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // index 0 is the oldest byte, the one on col_bytes
    logic [FIFO_DEPTH-1:0][7:0] store [COL_NUM];

    layer_cfg_t       cfg_q;
    col_idx_t         col_cnt;
    col_idx_t         restart_col;   // where the counter goes after last_col
    col_idx_t         load_col;
    col_idx_t         col_step;
    logic [CNT_W-1:0] shift_cnt;
    logic             wr_fire;

    assign busy     = (shift_cnt != '0);
    assign wr_ready = !busy;
    assign wr_fire  = wr_valid && wr_ready;

    // depthwise starts 3 columns early, modulo the column count
    assign load_col = (cfg.mode == MODE_DW) ? col_idx_t'(cfg.dw_start - col_idx_t'(3)) : '0;
    assign col_step = cfg_q.stride2 ? col_idx_t'(2) : col_idx_t'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q       <= '0;  // pointwise, stride 1
            col_cnt     <= '0;
            restart_col <= '0;
        end else if (cfg_load) begin
            cfg_q       <= cfg;
            col_cnt     <= load_col;
            restart_col <= load_col;
        end else if (wr_fire) begin
            if (col_cnt >= cfg_q.last_col) begin
                col_cnt <= restart_col;
            end else begin
                col_cnt <= col_cnt + col_step;
            end
        end
    end

    // four-cycle shift window
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_cnt <= '0;
        end else if (start) begin
            shift_cnt <= CNT_W'(FIFO_DEPTH);
        end else if (busy) begin
            shift_cnt <= shift_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < COL_NUM; c++) begin
                store[c] <= '0;
            end
        end else if (busy) begin
            for (int c = 0; c < COL_NUM; c++) begin
                store[c] <= {8'd0, store[c][FIFO_DEPTH-1:1]};  // shift toward output, zero fill
            end
        end else if (wr_fire) begin
            store[col_cnt] <= {wr_beat.b3, wr_beat.b2, wr_beat.b1, wr_beat.b0};
        end
    end

    always_comb begin
        for (int c = 0; c < COL_NUM; c++) begin
            col_bytes[c] = store[c][0];
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy);

    // the PE array relies on exactly four shift cycles
    a_shift_window: assert property (@(posedge clk) disable iff (reset)
        start |=> busy [*FIFO_DEPTH] ##1 !busy);

endmodule
